// ==== msk_tx_defines.svh ====
`ifndef MSK_TX_DEFINES_SVH
`define MSK_TX_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// ping-pong store layout

`define WORDS_PER_BANK     40    // 32-bit words per burst, 1280 bits
`define BANK1_BASE         6000  // bank 0 sits at address 0

////////////////////////////////////////////////////////////////////////////
// symbol shaping

`define SAMPLES_PER_SYMBOL 8     // half-sine samples per arm symbol
`define LEAD_SAMPLES       4     // half a symbol, the q offset

////////////////////////////////////////////////////////////////////////////
// dac pacing

`define PAIR_CLKS          4     // clk_50m cycles per i/q pair

`endif

// ==== msk_types_pkg.sv ====
package msk_types_pkg;

   // one word of the ping-pong store
   typedef logic [31:0] word_t;

   // store address, 14 bits covers both banks
   typedef logic [13:0] addr_t;

   // arm sample and dac word, two's complement
   // peak of the half-sine is 98079, fits in 18 bits signed
   typedef logic signed [17:0] sample_t;

endpackage

// ==== msk_ctrl_pkg.sv ====
package msk_ctrl_pkg;

   // word fetch from the ping-pong store
   typedef enum logic [1:0] {SEQ_IDLE, SEQ_ADDR, SEQ_WORD} seq_state_t;

   // per-arm sample generator
   typedef enum logic [1:0] {ARM_IDLE, ARM_LEAD, ARM_SYMBOL, ARM_TAIL} arm_state_t;

endpackage

// ==== msk_tx_ifs.sv ====
`timescale 1ns/1ps

// store word, sequencer to serializer
interface word_if;
   logic                   valid;
   logic                   ready;
   msk_types_pkg::word_t   data;
   logic                   last;     // final word of a burst
   modport source (output valid, data, last, input ready);
   modport sink   (input valid, data, last, output ready);
endinterface

// one msk symbol, serializer to arm
interface symbol_if;
   logic                   valid;
   logic                   ready;
   logic                   sym_bit;  // 1 = positive half-sine
   logic                   last;     // final symbol of a burst
   modport source (output valid, sym_bit, last, input ready);
   modport sink   (input valid, sym_bit, last, output ready);
endinterface

// shaped sample, arm to interleaver
interface sample_if;
   logic                   valid;
   logic                   ready;
   msk_types_pkg::sample_t sample;
   logic                   last;     // final sample of a burst
   modport source (output valid, sample, last, input ready);
   modport sink   (input valid, sample, last, output ready);
endinterface

// ==== slot_sequencer.sv ====
`timescale 1ns/1ps
`include "msk_tx_defines.svh"

module slot_sequencer (
   input  logic                  clk_50m,
   input  logic                  cfg_rst,
   input  logic                  slot_interrupt_i,
   input  logic                  dsp_start_send_i,
   input  msk_types_pkg::word_t  send_data_i,
   output msk_types_pkg::addr_t  read_addr_o,
   word_if.source                word_o
);

   msk_ctrl_pkg::seq_state_t state;
   logic [5:0]               word_cnt;   // 0..39 inside the bank
   logic                     bank;       // bank of the next or current burst
   logic                     trigger;
   logic                     word_fire;
   msk_types_pkg::addr_t     bank_base;

   assign trigger   = slot_interrupt_i & dsp_start_send_i;  // slot irq only counts when dsp enabled
   assign word_fire = word_o.valid & word_o.ready;
   assign bank_base = bank ? msk_types_pkg::addr_t'(`BANK1_BASE) : '0;

   // store data is forwarded straight through, it holds while the address holds
   assign word_o.valid = (state == msk_ctrl_pkg::SEQ_WORD);
   assign word_o.data  = send_data_i;
   assign word_o.last  = (word_cnt == 6'(`WORDS_PER_BANK - 1));

   ////////////////////////////////////////////////////////////////////////////
   // fetch fsm
   // idle -> addr (store latency) -> word (wait for serializer) -> addr ...

   always_ff @(posedge clk_50m or posedge cfg_rst) begin
      if (cfg_rst) begin
         state       <= msk_ctrl_pkg::SEQ_IDLE;
         word_cnt    <= '0;
         bank        <= 1'b0;                     // first burst from bank 0
         read_addr_o <= '0;
      end else begin
         case (state)
            msk_ctrl_pkg::SEQ_IDLE: begin
               if (trigger) begin
                  read_addr_o <= bank_base;       // word 0 of this bank
                  word_cnt    <= '0;
                  state       <= msk_ctrl_pkg::SEQ_ADDR;
               end
            end
            msk_ctrl_pkg::SEQ_ADDR: state <= msk_ctrl_pkg::SEQ_WORD;  // data valid next cycle
            msk_ctrl_pkg::SEQ_WORD: begin
               if (word_fire) begin
                  if (word_o.last) begin
                     state <= msk_ctrl_pkg::SEQ_IDLE;
                     bank  <= ~bank;              // ping-pong for the next slot
                  end else begin
                     word_cnt    <= word_cnt + 6'd1;
                     read_addr_o <= read_addr_o + 14'd1;
                     state       <= msk_ctrl_pkg::SEQ_ADDR;
                  end
               end
            end
            default: state <= msk_ctrl_pkg::SEQ_IDLE;
         endcase
      end
   end

endmodule

// ==== bit_serializer.sv ====
`timescale 1ns/1ps

module bit_serializer (
   input  logic      clk_50m,
   input  logic      cfg_rst,
   word_if.sink      word_i,
   symbol_if.source  sym_i_o,
   symbol_if.source  sym_q_o
);

   msk_types_pkg::word_t shreg;       // msb is the current i bit
   logic [3:0]           pair_cnt;    // 16 pairs per word
   logic                 busy;
   logic                 word_last;   // word closes the burst
   logic                 sent_i;      // i bit of this pair already taken
   logic                 sent_q;
   logic                 i_done;
   logic                 q_done;
   logic                 final_pair;

   assign final_pair   = (pair_cnt == 4'd15);
   assign word_i.ready = ~busy;              // only when both streams are drained

   assign sym_i_o.valid   = busy & ~sent_i;
   assign sym_i_o.sym_bit = shreg[31];       // bits 31, 29, ...
   assign sym_i_o.last    = word_last & final_pair;
   assign sym_q_o.valid   = busy & ~sent_q;
   assign sym_q_o.sym_bit = shreg[30];       // bits 30, 28, ...
   assign sym_q_o.last    = word_last & final_pair;

   assign i_done = sent_i | (sym_i_o.valid & sym_i_o.ready);
   assign q_done = sent_q | (sym_q_o.valid & sym_q_o.ready);

   always_ff @(posedge clk_50m or posedge cfg_rst) begin
      if (cfg_rst) begin
         busy      <= 1'b0;
         word_last <= 1'b0;
         pair_cnt  <= '0;
         sent_i    <= 1'b0;
         sent_q    <= 1'b0;
      end else if (word_i.valid & word_i.ready) begin
         busy      <= 1'b1;
         word_last <= word_i.last;
         pair_cnt  <= '0;
      end else if (busy) begin
         if (i_done & q_done) begin          // pair complete, step on
            pair_cnt <= pair_cnt + 4'd1;
            sent_i   <= 1'b0;
            sent_q   <= 1'b0;
            if (final_pair)
               busy <= 1'b0;
         end else begin
            sent_i <= i_done;                 // one arm may lag the other
            sent_q <= q_done;
         end
      end
   end

   // shift register, msb first, two bits per pair
   always_ff @(posedge clk_50m) begin
      if (word_i.valid & word_i.ready)
         shreg <= word_i.data;
      else if (busy & i_done & q_done)
         shreg <= {shreg[29:0], 2'b00};
   end

endmodule

// ==== msk_arm.sv ====
`timescale 1ns/1ps
`include "msk_tx_defines.svh"

module msk_arm #(
   parameter bit LEAD_ZEROS = 1'b0   // 1 = q arm, zero lead; 0 = i arm, zero tail
) (
   input  logic      clk_50m,
   input  logic      cfg_rst,
   symbol_if.sink    sym_i,
   sample_if.source  smp_o
);

   localparam logic [2:0] LAST_IDX  = 3'(`SAMPLES_PER_SYMBOL - 1);
   localparam logic [2:0] LEAD_LAST = 3'(`LEAD_SAMPLES - 1);

   msk_ctrl_pkg::arm_state_t state;
   logic [2:0]               idx;          // sample index in symbol, lead or tail
   logic                     pend_valid;   // one-symbol holding register
   logic                     pend_bit;
   logic                     pend_last;
   logic                     cur_bit;      // symbol playing out
   logic                     cur_last;
   logic                     in_burst;
   logic                     smp_fire;
   logic                     load_pend;
   msk_types_pkg::sample_t   shape;

   // 100000 * sin(pi*(k+0.5)/8), symmetric about the middle
   function automatic msk_types_pkg::sample_t half_sine(input logic [2:0] k);
      case (k)
         3'd0, 3'd7: half_sine = 18'sd19509;
         3'd1, 3'd6: half_sine = 18'sd55557;
         3'd2, 3'd5: half_sine = 18'sd83147;
         3'd3, 3'd4: half_sine = 18'sd98079;
      endcase
   endfunction

   assign sym_i.ready = ~pend_valid;
   assign smp_fire    = smp_o.valid & smp_o.ready;
   assign shape       = half_sine(idx);

   assign smp_o.valid  = (state != msk_ctrl_pkg::ARM_IDLE);
   assign smp_o.sample = (state != msk_ctrl_pkg::ARM_SYMBOL) ? '0 :   // lead/tail are zeros
                         (cur_bit ? shape : -shape);                   // 0 bit negated
   assign smp_o.last   = ((state == msk_ctrl_pkg::ARM_SYMBOL) & LEAD_ZEROS & cur_last &
                          (idx == LAST_IDX)) |
                         ((state == msk_ctrl_pkg::ARM_TAIL) & (idx == LEAD_LAST));

   // pending symbol moves into play
   always_comb begin
      case (state)
         msk_ctrl_pkg::ARM_IDLE:   load_pend = pend_valid & (in_burst | ~LEAD_ZEROS);
         msk_ctrl_pkg::ARM_LEAD:   load_pend = smp_fire & (idx == LEAD_LAST);
         msk_ctrl_pkg::ARM_SYMBOL: load_pend = smp_fire & (idx == LAST_IDX) & ~cur_last &
                                               pend_valid;
         default:                  load_pend = 1'b0;
      endcase
   end

   always_ff @(posedge clk_50m or posedge cfg_rst) begin
      if (cfg_rst) begin
         state      <= msk_ctrl_pkg::ARM_IDLE;
         idx        <= '0;
         pend_valid <= 1'b0;
         in_burst   <= 1'b0;
      end else begin
         if (sym_i.valid & sym_i.ready)
            pend_valid <= 1'b1;
         else if (load_pend)
            pend_valid <= 1'b0;

         if (load_pend) begin
            state    <= msk_ctrl_pkg::ARM_SYMBOL;
            idx      <= '0;
            in_burst <= 1'b1;
         end else begin
            case (state)
               msk_ctrl_pkg::ARM_IDLE: begin
                  if (pend_valid) begin               // q arm, burst start
                     state <= msk_ctrl_pkg::ARM_LEAD;
                     idx   <= '0;
                  end
               end
               msk_ctrl_pkg::ARM_SYMBOL: begin
                  if (smp_fire & (idx == LAST_IDX)) begin
                     idx <= '0;
                     if (cur_last) begin
                        in_burst <= 1'b0;
                        state    <= LEAD_ZEROS ? msk_ctrl_pkg::ARM_IDLE
                                               : msk_ctrl_pkg::ARM_TAIL;
                     end else begin
                        state <= msk_ctrl_pkg::ARM_IDLE;  // next symbol not here yet
                     end
                  end else if (smp_fire) begin
                     idx <= idx + 3'd1;
                  end
               end
               msk_ctrl_pkg::ARM_TAIL: begin
                  if (smp_fire) begin
                     idx <= (idx == LEAD_LAST) ? 3'd0 : idx + 3'd1;
                     if (idx == LEAD_LAST)
                        state <= msk_ctrl_pkg::ARM_IDLE;
                  end
               end
               default: if (smp_fire) idx <= idx + 3'd1;  // lead count
            endcase
         end
      end
   end

   // symbol payload
   always_ff @(posedge clk_50m) begin
      if (sym_i.valid & sym_i.ready) begin
         pend_bit  <= sym_i.sym_bit;
         pend_last <= sym_i.last;
      end
      if (load_pend) begin
         cur_bit  <= pend_bit;
         cur_last <= pend_last;
      end
   end

endmodule

// ==== dac_interleaver.sv ====
`timescale 1ns/1ps
`include "msk_tx_defines.svh"

module dac_interleaver (
   input  logic                    clk_50m,
   input  logic                    cfg_rst,
   sample_if.sink                  smp_i_i,
   sample_if.sink                  smp_q_i,
   output msk_types_pkg::sample_t  dac_out_o,
   output logic                    dac_tx_en_o,
   output logic                    dac_iq_sel_o,   // 0 = i, 1 = q
   output logic                    burst_done_o
);

   localparam int                RATE_W    = $clog2(`PAIR_CLKS);
   localparam logic [RATE_W-1:0] RATE_LAST = RATE_W'(`PAIR_CLKS - 1);

   logic [RATE_W-1:0]      rate_cnt;
   logic                   strobe;
   logic                   take;        // joint accept of both arms
   logic                   q_pend;      // q word goes out next cycle
   logic                   pair_last;
   msk_types_pkg::sample_t q_hold;

   assign strobe = (rate_cnt == RATE_LAST);
   assign take   = strobe & smp_i_i.valid & smp_q_i.valid;  // never one arm alone

   assign smp_i_i.ready = take;
   assign smp_q_i.ready = take;

   ////////////////////////////////////////////////////////////////////////////
   // dac rate and output sequence: strobe -> i -> q

   always_ff @(posedge clk_50m or posedge cfg_rst) begin
      if (cfg_rst) begin
         rate_cnt     <= '0;
         dac_out_o    <= '0;
         dac_tx_en_o  <= 1'b0;
         dac_iq_sel_o <= 1'b0;
         burst_done_o <= 1'b0;
         q_pend       <= 1'b0;
         pair_last    <= 1'b0;
      end else begin
         rate_cnt <= strobe ? '0 : rate_cnt + 1'b1;   // free running
         if (take) begin
            dac_out_o    <= smp_i_i.sample;
            dac_tx_en_o  <= 1'b1;
            dac_iq_sel_o <= 1'b0;
            burst_done_o <= 1'b0;
            q_pend       <= 1'b1;
            pair_last    <= smp_i_i.last & smp_q_i.last;
         end else if (q_pend) begin
            dac_out_o    <= q_hold;
            dac_tx_en_o  <= 1'b1;
            dac_iq_sel_o <= 1'b1;
            burst_done_o <= pair_last;                 // with the closing q sample
            q_pend       <= 1'b0;
         end else begin
            dac_tx_en_o  <= 1'b0;                      // dac_out_o keeps last value
            dac_iq_sel_o <= 1'b0;
            burst_done_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_50m) begin
      if (take)
         q_hold <= smp_q_i.sample;
   end

endmodule

// ==== msk_tx_top.sv ====
`timescale 1ns/1ps

module msk_tx_top (
   input  logic                    clk_50m,
   input  logic                    cfg_rst,
   input  logic                    slot_interrupt_i,
   input  logic                    dsp_start_send_i,
   input  msk_types_pkg::word_t    send_data_i,
   output msk_types_pkg::addr_t    read_addr_o,
   output msk_types_pkg::sample_t  dac_out_o,
   output logic                    dac_tx_en_o,
   output logic                    dac_iq_sel_o,
   output logic                    burst_done_o
);

   word_if   word_bus ();
   symbol_if sym_i ();
   symbol_if sym_q ();
   sample_if smp_i ();
   sample_if smp_q ();

   ////////////////////////////////////////////////////////////////////////////
   // store fetch and bit split

   slot_sequencer u_seq (
      .clk_50m          (clk_50m),
      .cfg_rst          (cfg_rst),
      .slot_interrupt_i (slot_interrupt_i),
      .dsp_start_send_i (dsp_start_send_i),
      .send_data_i      (send_data_i),
      .read_addr_o      (read_addr_o),
      .word_o           (word_bus)
   );

   bit_serializer u_ser (
      .clk_50m (clk_50m),
      .cfg_rst (cfg_rst),
      .word_i  (word_bus),
      .sym_i_o (sym_i),
      .sym_q_o (sym_q)
   );

   ////////////////////////////////////////////////////////////////////////////
   // i and q arms, q half a symbol late

   msk_arm #(.LEAD_ZEROS(1'b0)) u_arm_i (
      .clk_50m (clk_50m),
      .cfg_rst (cfg_rst),
      .sym_i   (sym_i),
      .smp_o   (smp_i)
   );

   msk_arm #(.LEAD_ZEROS(1'b1)) u_arm_q (
      .clk_50m (clk_50m),
      .cfg_rst (cfg_rst),
      .sym_i   (sym_q),
      .smp_o   (smp_q)
   );

   dac_interleaver u_ilv (
      .clk_50m      (clk_50m),
      .cfg_rst      (cfg_rst),
      .smp_i_i      (smp_i),
      .smp_q_i      (smp_q),
      .dac_out_o    (dac_out_o),
      .dac_tx_en_o  (dac_tx_en_o),
      .dac_iq_sel_o (dac_iq_sel_o),
      .burst_done_o (burst_done_o)
   );

endmodule

// ==== msk_tx_tb.sv ====
`timescale 1ns/1ps
`include "msk_tx_defines.svh"

module msk_tx_tb;

   localparam int BURST_SAMPLES = `WORDS_PER_BANK * 16 * `SAMPLES_PER_SYMBOL + `LEAD_SAMPLES;

   logic                   clk_50m = 1'b0;
   logic                   cfg_rst;
   logic                   slot_interrupt_i;
   logic                   dsp_start_send_i;
   msk_types_pkg::word_t   send_data_i = '0;
   msk_types_pkg::addr_t   read_addr_o;
   msk_types_pkg::sample_t dac_out_o;
   logic                   dac_tx_en_o;
   logic                   dac_iq_sel_o;
   logic                   burst_done_o;

   msk_types_pkg::word_t   stim_mem [0:16];       // burst count, then 16 store words
   msk_types_pkg::sample_t exp_i_q [$];
   msk_types_pkg::sample_t exp_q_q [$];
   msk_types_pkg::addr_t   exp_addr_q [$];
   msk_types_pkg::sample_t exp_smp;
   msk_types_pkg::addr_t   exp_addr;
   msk_types_pkg::addr_t   last_addr;
   logic                   addr_seen = 1'b0;
   logic                   q_due = 1'b0;          // q must follow the i just sent
   logic [31:0]            rng_state = 32'hba6d_53f2;
   int                     gaps [$];
   int                     n_bursts;
   int                     limit_cycles = 0;
   int                     bursts_seen = 0;
   int                     cyc = 0;
   int                     last_i_cyc = 0;
   int                     i_in_burst = 0;
   int                     q_in_burst = 0;

   msk_tx_top msk_tx_top_i (.*);

   always #10 clk_50m = ~clk_50m;                   // 50 MHz

   // ping-pong store model with one cycle read latency and a repeating 16-word image
   always @(posedge clk_50m) send_data_i <= stim_mem[1 + read_addr_o[3:0]];

   ////////////////////////////////////////////////////////////////////////////
   // reporting and reference model

   task automatic abort_run();
      $display("SOME TESTS FAILED");
      $fatal(1);
   endtask

   task automatic report_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      abort_run();
   endtask

   task automatic report_text(input string what);
      $display("%s", what);
      abort_run();
   endtask

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      lcg_next = s * 32'd1664525 + 32'd1013904223;
   endfunction

   // rounded 100000 * sin(pi*(k+0.5)/8)
   function automatic msk_types_pkg::sample_t shape_value(input int k);
      real phase;
      phase = 3.14159265358979 * (real'(k) + 0.5) / real'(`SAMPLES_PER_SYMBOL);
      shape_value = msk_types_pkg::sample_t'($rtoi(100000.0 * $sin(phase) + 0.5));
   endfunction

   task automatic build_expected();
      int                   b;
      int                   n;
      int                   p;
      int                   k;
      int                   base;
      msk_types_pkg::word_t w;
      for (b = 0; b < n_bursts; b++) begin
         base = (b % 2 == 1) ? `BANK1_BASE : 0;      // banks alternate per burst
         for (n = 0; n < `LEAD_SAMPLES; n++)
            exp_q_q.push_back('0);                  // q starts half a symbol late
         for (n = 0; n < `WORDS_PER_BANK; n++) begin
            exp_addr_q.push_back(msk_types_pkg::addr_t'(base + n));
            w = stim_mem[1 + (base + n) % 16];
            for (p = 0; p < 16; p++) begin
               for (k = 0; k < `SAMPLES_PER_SYMBOL; k++) begin
                  exp_i_q.push_back(w[31 - 2 * p] ? shape_value(k) : -shape_value(k));
                  exp_q_q.push_back(w[30 - 2 * p] ? shape_value(k) : -shape_value(k));
               end
            end
         end
         for (n = 0; n < `LEAD_SAMPLES; n++)
            exp_i_q.push_back('0);                  // i tail
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // monitors sample mid-cycle on the falling edge

   always @(negedge clk_50m) begin
      if (!cfg_rst && (!addr_seen || read_addr_o != last_addr)) begin
         assert (exp_addr_q.size() != 0)
            else report_text("read_addr_o moved after the last expected address");
         exp_addr = exp_addr_q.pop_front();
         assert (read_addr_o == exp_addr)
            else report_value("read_addr_o", 32'(read_addr_o), 32'(exp_addr));
         last_addr = read_addr_o;
         addr_seen = 1'b1;
      end
   end

   always @(negedge clk_50m) begin
      if (!cfg_rst) begin
         cyc++;
         if (dac_tx_en_o && !dac_iq_sel_o) begin      // i sample
            assert (!q_due) else report_text("I sample came where a Q sample was due");
            if (i_in_burst > 0) begin
               assert (cyc - last_i_cyc == `PAIR_CLKS)
                  else report_value("dac_tx_en_o I spacing", cyc - last_i_cyc, `PAIR_CLKS);
            end
            assert (exp_i_q.size() != 0) else report_text("more I samples than expected");
            exp_smp = exp_i_q.pop_front();
            assert (dac_out_o == exp_smp)
               else report_value("dac_out_o (I)", {14'd0, dac_out_o}, {14'd0, exp_smp});
            assert (!burst_done_o) else report_value("burst_done_o", 1, 0);
            last_i_cyc = cyc;
            i_in_burst++;
            q_due = 1'b1;
         end else if (dac_tx_en_o) begin              // q sample
            assert (q_due) else report_text("Q sample without an I sample just before it");
            assert (exp_q_q.size() != 0) else report_text("more Q samples than expected");
            exp_smp = exp_q_q.pop_front();
            assert (dac_out_o == exp_smp)
               else report_value("dac_out_o (Q)", {14'd0, dac_out_o}, {14'd0, exp_smp});
            q_in_burst++;
            assert (burst_done_o == (q_in_burst == BURST_SAMPLES))
               else report_value("burst_done_o", 32'(burst_done_o),
                                 32'(q_in_burst == BURST_SAMPLES));
            if (burst_done_o) begin
               bursts_seen++;
               i_in_burst = 0;
               q_in_burst = 0;
            end
            q_due = 1'b0;
         end else begin
            assert (!q_due) else report_text("Q sample missing one cycle after the I sample");
            assert (!burst_done_o) else report_value("burst_done_o", 1, 0);
         end
      end
   end

   // watchdog budget grows with burst length and idle gaps
   initial begin
      wait (limit_cycles != 0);
      repeat (limit_cycles) @(posedge clk_50m);
      report_text("timeout: the bursts did not complete in the allowed cycles");
   end

   ////////////////////////////////////////////////////////////////////////////
   // stimulus

   // slot irq with dsp send off must leave the address parked on word 39 and the dac idle
   task automatic check_disabled_slot(input int burst);
      int                   base;
      msk_types_pkg::addr_t park_addr;
      base      = (burst % 2 == 1) ? `BANK1_BASE : 0;   // bank of the burst just sent
      park_addr = msk_types_pkg::addr_t'(base + `WORDS_PER_BANK - 1);
      @(posedge clk_50m);
      dsp_start_send_i <= 1'b0;
      slot_interrupt_i <= 1'b1;
      @(posedge clk_50m);
      slot_interrupt_i <= 1'b0;
      repeat (100) begin
         @(negedge clk_50m);
         assert (read_addr_o == park_addr)
            else report_value("read_addr_o", 32'(read_addr_o), 32'(park_addr));
         assert (!dac_tx_en_o) else report_value("dac_tx_en_o", 1, 0);
      end
   endtask

   task automatic finish_run();
      assert (bursts_seen == n_bursts)
         else report_value("burst_done_o pulse count", bursts_seen, n_bursts);
      assert (exp_i_q.size() == 0) else report_text("I samples missing at the end");
      assert (exp_q_q.size() == 0) else report_text("Q samples missing at the end");
      assert (exp_addr_q.size() == 0) else report_text("read_addr_o skipped addresses");
      $display("ALL TESTS PASSED");
      $finish;
   endtask

   initial begin : main_seq
      int b;
      int gap_sum;
      gap_sum = 0;
      cfg_rst = 1'b1;
      slot_interrupt_i = 1'b0;
      dsp_start_send_i = 1'b0;
      $readmemh("msk_tx_stimulus.txt", stim_mem);
      n_bursts = int'(stim_mem[0]);
      build_expected();
      for (b = 0; b < n_bursts; b++) begin
         rng_state = lcg_next(rng_state);
         gaps.push_back(5 + int'(rng_state[23:8] % 16'd56));   // 5..60 idle cycles
         gap_sum += gaps[b];
      end
      limit_cycles = n_bursts * (BURST_SAMPLES * `PAIR_CLKS + 200 + 110) + gap_sum + 20;
      repeat (5) @(posedge clk_50m);
      cfg_rst <= 1'b0;
      for (b = 0; b < n_bursts; b++) begin
         @(posedge clk_50m);
         dsp_start_send_i <= 1'b1;
         slot_interrupt_i <= 1'b1;
         @(posedge clk_50m);
         slot_interrupt_i <= 1'b0;
         repeat (9) @(posedge clk_50m);
         slot_interrupt_i <= 1'b1;                    // lands mid-burst and gets dropped
         @(posedge clk_50m);
         slot_interrupt_i <= 1'b0;
         while (bursts_seen < b + 1) @(posedge clk_50m);
         check_disabled_slot(b);
         repeat (gaps[b]) @(posedge clk_50m);
      end
      finish_run();
   end

endmodule

// ==== msk_tx.f ====
+incdir+.
msk_types_pkg.sv
msk_ctrl_pkg.sv
msk_tx_ifs.sv
slot_sequencer.sv
bit_serializer.sv
msk_arm.sv
dac_interleaver.sv
msk_tx_top.sv
msk_tx_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module msk_tx_tb -f msk_tx.f -o msk_tx_sim &&
./obj_dir/msk_tx_sim ||
{ echo "build or simulation of msk_tx_tb did not complete cleanly"; exit 1; }

// ==== msk_tx_stimulus.txt ====
// line 1: number of bursts (hex)
// lines 2-17: store words for address mod 16, word 0 first (hex)
3
a5a5a5a5
00000000
ffffffff
5a5a5a5a
0f0f0f0f
f0f0f0f0
12345678
9abcdef0
c3c3c33c
80000001
7ffffffe
33cc33cc
01234567
fedcba98
69966996
e1d2c3b4
